/* design/axi_bus_pkg.sv */
// AXI channel payloads for the single-beat CSR slave
// Valid and ready travel as separate wires next to these structs
`include "axi_csr_settings.svh"
`default_nettype none

package axi_bus_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Read address, 52 bits
  typedef struct packed {
    logic [`AXI_CSR_ADDR_W-1:0] addr;
    logic [`AXI_CSR_ID_W-1:0]   id;
    logic [`AXI_CSR_USER_W-1:0] user;
  } axi_ar_t;

  typedef axi_ar_t axi_aw_t;  // Same layout as AR

  typedef struct packed {
    logic [`AXI_CSR_DATA_W-1:0]   data;
    logic [`AXI_CSR_DATA_W/8-1:0] strb;
    logic [`AXI_CSR_USER_W-1:0]   user;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_CSR_DATA_W-1:0] data;
    axi_resp_e                  resp;
    logic [`AXI_CSR_ID_W-1:0]   id;
    logic [`AXI_CSR_USER_W-1:0] user;
    logic                       last;
  } axi_r_t;

  typedef struct packed {
    axi_resp_e                  resp;
    logic [`AXI_CSR_ID_W-1:0]   id;
    logic [`AXI_CSR_USER_W-1:0] user;
  } axi_b_t;

endpackage

`default_nettype wire

/* design/axi_csr_adapter.sv */
// AXI slave for single-beat accesses, one transaction at a time
// Turns each read or write into a req pulse on the CPU interface
`include "axi_csr_settings.svh"
`default_nettype none

module axi_csr_adapter (
  input  wire logic                 aclk,
  input  wire logic                 areset_n,
  input  wire axi_bus_pkg::axi_ar_t ar_i,
  input  wire logic                 ar_valid_i,
  output logic                      ar_ready_o,
  input  wire axi_bus_pkg::axi_aw_t aw_i,
  input  wire logic                 aw_valid_i,
  output logic                      aw_ready_o,
  input  wire axi_bus_pkg::axi_w_t  w_i,
  input  wire logic                 w_valid_i,
  output logic                      w_ready_o,
  output axi_bus_pkg::axi_r_t       r_o,
  output logic                      r_valid_o,
  input  wire logic                 r_ready_i,
  output axi_bus_pkg::axi_b_t       b_o,
  output logic                      b_valid_o,
  input  wire logic                 b_ready_i,
  output csr_pkg::csr_req_t         csr_req_o,
  output logic                      csr_req_valid_o,
  input  wire csr_pkg::csr_rsp_t    csr_rsp_i
);
  import axi_bus_pkg::*;
  import csr_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, WRITE, RESP} state_e;

  state_e                     state_q;
  logic                       aw_held_q, w_held_q, req_q;
  axi_aw_t                    aw_q, aw_cur;
  axi_w_t                     w_q, w_cur;
  csr_req_t                   creq_q;
  logic [`AXI_CSR_ID_W-1:0]   id_q;
  logic [`AXI_CSR_USER_W-1:0] user_q;
  logic [`AXI_CSR_DATA_W-1:0] rdata_q;
  axi_resp_e                  resp_q;
  logic                       ar_hs, aw_hs, w_hs, wr_go, ack;

  function automatic logic [`AXI_CSR_DATA_W-1:0] strb_to_mask(
    input logic [`AXI_CSR_DATA_W/8-1:0] strb
  );
    logic [`AXI_CSR_DATA_W-1:0] mask;
    for (int i = 0; i < `AXI_CSR_DATA_W/8; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  assign ar_hs  = ar_valid_i & ar_ready_o;
  assign aw_hs  = aw_valid_i & aw_ready_o;
  assign w_hs   = w_valid_i & w_ready_o;
  assign aw_cur = aw_held_q ? aw_q : aw_i;
  assign w_cur  = w_held_q ? w_q : w_i;
  assign wr_go  = (aw_held_q | aw_hs) & (w_held_q | w_hs);  // Both halves present
  assign ack    = ((state_q == READ) | (state_q == WRITE)) & (csr_rsp_i.rd_ack | csr_rsp_i.wr_ack);

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      state_q   <= IDLE;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      req_q     <= 1'b0;
    end else begin
      req_q <= 1'b0;
      if (aw_hs) aw_held_q <= 1'b1;
      if (w_hs) w_held_q <= 1'b1;
      case (state_q)
        IDLE: begin
          if (ar_hs) begin  // Reads win over a complete write
            state_q <= READ;
            req_q   <= 1'b1;
          end else if (wr_go) begin
            state_q   <= WRITE;
            req_q     <= 1'b1;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
          end
        end
        READ, WRITE: if (ack) state_q <= RESP;
        RESP: if ((r_valid_o & r_ready_i) | (b_valid_o & b_ready_i)) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_hs) aw_q <= aw_i;
    if (w_hs) w_q <= w_i;
    if (state_q == IDLE && ar_hs) begin
      creq_q <= '{is_wr: 1'b0, addr: ar_i.addr[`AXI_CSR_ADDR_W-1:2],
                  wr_data: '0, wr_biten: '0};
      id_q   <= ar_i.id;
      user_q <= ar_i.user;
    end else if (state_q == IDLE && wr_go) begin
      creq_q <= '{is_wr: 1'b1, addr: aw_cur.addr[`AXI_CSR_ADDR_W-1:2],
                  wr_data: w_cur.data, wr_biten: strb_to_mask(w_cur.strb)};
      id_q   <= aw_cur.id;
      user_q <= aw_cur.user;
    end
    if (ack) begin
      rdata_q <= csr_rsp_i.rd_data;
      resp_q  <= csr_rsp_i.err ? SLVERR : OKAY;
    end
  end

  // No new beats while a transaction is in flight
  assign ar_ready_o = (state_q == IDLE);
  assign aw_ready_o = (state_q == IDLE) & ~aw_held_q;
  assign w_ready_o  = (state_q == IDLE) & ~w_held_q;

  assign r_valid_o = (state_q == RESP) & ~creq_q.is_wr;
  assign b_valid_o = (state_q == RESP) & creq_q.is_wr;
  assign r_o = '{data: rdata_q, resp: resp_q, id: id_q, user: user_q, last: 1'b1};
  assign b_o = '{resp: resp_q, id: id_q, user: user_q};

  assign csr_req_o       = creq_q;
  assign csr_req_valid_o = req_q;

endmodule

`default_nettype wire

/* design/axi_csr_settings.svh */
// Widths, FIFO depth and ID constant for the AXI CSR harness
// Include before any package or module that uses them
`ifndef AXI_CSR_SETTINGS_SVH
`define AXI_CSR_SETTINGS_SVH

`define AXI_CSR_ADDR_W     12
`define AXI_CSR_DATA_W     32
`define AXI_CSR_ID_W       8
`define AXI_CSR_USER_W     32

// Stress FIFO behind TX_DATA_PORT and INDIRECT_FIFO_DATA
`define AXI_CSR_FIFO_DEPTH 128
`define AXI_CSR_DEPTH_W    8

`define AXI_CSR_ID_VALUE   32'h1c3c_0001

`endif

/* design/axi_csr_top.sv */
// AXI CSR harness top: adapter, register block, port bridge and stress FIFO
// FIFO depth and full flag are brought out for the testbench
`include "axi_csr_settings.svh"
`default_nettype none

module axi_csr_top (
  input  wire logic                 aclk,
  input  wire logic                 areset_n,
  input  wire axi_bus_pkg::axi_ar_t ar_i,
  input  wire logic                 ar_valid_i,
  output logic                      ar_ready_o,
  input  wire axi_bus_pkg::axi_aw_t aw_i,
  input  wire logic                 aw_valid_i,
  output logic                      aw_ready_o,
  input  wire axi_bus_pkg::axi_w_t  w_i,
  input  wire logic                 w_valid_i,
  output logic                      w_ready_o,
  output axi_bus_pkg::axi_r_t       r_o,
  output logic                      r_valid_o,
  input  wire logic                 r_ready_i,
  output axi_bus_pkg::axi_b_t       b_o,
  output logic                      b_valid_o,
  input  wire logic                 b_ready_i,
  output logic [`AXI_CSR_DEPTH_W-1:0] fifo_depth_o,
  output logic                      fifo_full_o
);
  import csr_pkg::*;

  csr_req_t   csr_req;
  logic       csr_req_valid;
  csr_rsp_t   csr_rsp;
  port_req_t  port_req;
  port_rsp_t  port_rsp;
  logic       fifo_wvalid, fifo_wready, fifo_rvalid, fifo_rready;
  fifo_word_t fifo_wdata, fifo_rdata;

  axi_csr_adapter adapter_i (
    .aclk, .areset_n,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .b_o, .b_valid_o, .b_ready_i,
    .csr_req_o(csr_req), .csr_req_valid_o(csr_req_valid), .csr_rsp_i(csr_rsp)
  );

  csr_regs regs_i (
    .aclk, .areset_n,
    .csr_req_i(csr_req), .csr_req_valid_i(csr_req_valid), .csr_rsp_o(csr_rsp),
    .port_req_o(port_req), .port_rsp_i(port_rsp),
    .fifo_depth_i(fifo_depth_o), .fifo_full_i(fifo_full_o)
  );

  fifo_port_bridge bridge_i (
    .aclk, .areset_n,
    .port_req_i(port_req), .port_rsp_o(port_rsp),
    .fifo_wvalid_o(fifo_wvalid), .fifo_wready_i(fifo_wready), .fifo_wdata_o(fifo_wdata),
    .fifo_rvalid_i(fifo_rvalid), .fifo_rready_o(fifo_rready), .fifo_rdata_i(fifo_rdata)
  );

  sync_fifo #(.T(fifo_word_t), .Depth(`AXI_CSR_FIFO_DEPTH)) fifo_i (
    .aclk, .areset_n,
    .wvalid_i(fifo_wvalid), .wready_o(fifo_wready), .wdata_i(fifo_wdata),
    .rvalid_o(fifo_rvalid), .rready_i(fifo_rready), .rdata_o(fifo_rdata),
    .depth_o(fifo_depth_o), .full_o(fifo_full_o)
  );

endmodule

`default_nettype wire

/* design/csr_pkg.sv */
// CPU-interface and FIFO-port types plus the register map
// Offsets are byte offsets within the AXI window
`include "axi_csr_settings.svh"
`default_nettype none

package csr_pkg;

  localparam int unsigned CSR_ADDR_W = `AXI_CSR_ADDR_W - 2;  // Word address

  localparam logic [`AXI_CSR_ADDR_W-1:0] ID_OFS        = 'h00;
  localparam logic [`AXI_CSR_ADDR_W-1:0] SCRATCH_OFS   = 'h04;
  localparam logic [`AXI_CSR_ADDR_W-1:0] TX_DATA_OFS   = 'h08;
  localparam logic [`AXI_CSR_ADDR_W-1:0] FIFO_DATA_OFS = 'h0c;
  localparam logic [`AXI_CSR_ADDR_W-1:0] STATUS_OFS    = 'h10;

  typedef logic [`AXI_CSR_DATA_W-1:0] fifo_word_t;

  // Qualified by a separate one-cycle req pulse
  typedef struct packed {
    logic                       is_wr;
    logic [CSR_ADDR_W-1:0]      addr;
    logic [`AXI_CSR_DATA_W-1:0] wr_data;
    logic [`AXI_CSR_DATA_W-1:0] wr_biten;
  } csr_req_t;

  typedef struct packed {
    logic                       rd_ack;
    logic                       wr_ack;
    logic                       err;
    logic [`AXI_CSR_DATA_W-1:0] rd_data;
  } csr_rsp_t;

  typedef struct packed {
    logic       push;
    logic       pop;
    fifo_word_t wr_data;
  } port_req_t;

  typedef struct packed {
    logic       ack;
    logic       err;
    fifo_word_t rd_data;
  } port_rsp_t;

endpackage

`default_nettype wire

/* design/csr_regs.sv */
// Register block behind the CPU interface
// Plain registers ack after one cycle, FIFO ports ack through the bridge
`include "axi_csr_settings.svh"
`default_nettype none

module csr_regs (
  input  wire logic                        aclk,
  input  wire logic                        areset_n,
  input  wire csr_pkg::csr_req_t           csr_req_i,
  input  wire logic                        csr_req_valid_i,
  output csr_pkg::csr_rsp_t                csr_rsp_o,
  output csr_pkg::port_req_t               port_req_o,
  input  wire csr_pkg::port_rsp_t          port_rsp_i,
  input  wire logic [`AXI_CSR_DEPTH_W-1:0] fifo_depth_i,
  input  wire logic                        fifo_full_i
);
  import csr_pkg::*;

  logic [`AXI_CSR_ADDR_W-1:0] ofs;
  logic                       push, pop, loc_ack, loc_err;
  logic [`AXI_CSR_DATA_W-1:0] loc_data, status;
  logic [`AXI_CSR_DATA_W-1:0] scratch_q, loc_data_q;
  logic                       loc_ack_q, loc_err_q, rd_q;

  assign ofs     = {csr_req_i.addr, 2'b00};
  assign push    = csr_req_valid_i & csr_req_i.is_wr & (ofs == TX_DATA_OFS);
  assign pop     = csr_req_valid_i & ~csr_req_i.is_wr & (ofs == FIFO_DATA_OFS);
  assign loc_ack = csr_req_valid_i & ~push & ~pop;

  assign port_req_o = '{push: push, pop: pop, wr_data: csr_req_i.wr_data};

  always_comb begin
    status = '0;
    status[`AXI_CSR_DEPTH_W-1:0] = fifo_depth_i;
    status[`AXI_CSR_DEPTH_W]     = fifo_full_i;
  end

  always_comb begin
    loc_err  = 1'b0;
    loc_data = '0;
    case (ofs)
      ID_OFS:        loc_data = `AXI_CSR_ID_VALUE;
      SCRATCH_OFS:   loc_data = scratch_q;
      TX_DATA_OFS:   loc_data = '0;  // Reads back zero
      FIFO_DATA_OFS: loc_err  = csr_req_i.is_wr;
      STATUS_OFS:    loc_data = status;
      default:       loc_err  = 1'b1;
    endcase
    if (csr_req_i.is_wr) loc_data = '0;
  end

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      loc_ack_q <= 1'b0;
      rd_q      <= 1'b0;
      scratch_q <= '0;
    end else begin
      loc_ack_q <= loc_ack;
      if (csr_req_valid_i) rd_q <= ~csr_req_i.is_wr;  // Direction of the open request
      if (loc_ack && csr_req_i.is_wr && ofs == SCRATCH_OFS) begin
        scratch_q <= (scratch_q & ~csr_req_i.wr_biten) |
                     (csr_req_i.wr_data & csr_req_i.wr_biten);
      end
    end
  end

  always_ff @(posedge aclk) begin
    loc_err_q  <= loc_err;
    loc_data_q <= loc_data;
  end

  // Port acks go straight through
  assign csr_rsp_o = '{
    rd_ack:  (loc_ack_q | port_rsp_i.ack) & rd_q,
    wr_ack:  (loc_ack_q | port_rsp_i.ack) & ~rd_q,
    err:     loc_ack_q ? loc_err_q : port_rsp_i.err,
    rd_data: loc_ack_q ? loc_data_q : port_rsp_i.rd_data
  };

endmodule

`default_nettype wire

/* design/fifo_port_bridge.sv */
// Turns TX_DATA_PORT and INDIRECT_FIFO_DATA requests into FIFO push and pop
// Request is registered for one cycle, the ack follows one cycle later
`default_nettype none

module fifo_port_bridge (
  input  wire logic                aclk,
  input  wire logic                areset_n,
  input  wire csr_pkg::port_req_t  port_req_i,
  output csr_pkg::port_rsp_t       port_rsp_o,
  output logic                     fifo_wvalid_o,
  input  wire logic                fifo_wready_i,
  output csr_pkg::fifo_word_t      fifo_wdata_o,
  input  wire logic                fifo_rvalid_i,
  output logic                     fifo_rready_o,
  input  wire csr_pkg::fifo_word_t fifo_rdata_i
);
  import csr_pkg::*;

  logic       push_q, pop_q, ack_q, err_q;
  fifo_word_t wdata_q, rdata_q;

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      push_q <= 1'b0;
      pop_q  <= 1'b0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      push_q <= port_req_i.push;
      pop_q  <= port_req_i.pop;
      ack_q  <= push_q | pop_q;
      err_q  <= (push_q & ~fifo_wready_i) | (pop_q & ~fifo_rvalid_i);  // Full or empty
    end
  end

  always_ff @(posedge aclk) begin
    wdata_q <= port_req_i.wr_data;
    rdata_q <= (pop_q && fifo_rvalid_i) ? fifo_rdata_i : '0;
  end

  assign fifo_wvalid_o = push_q;
  assign fifo_wdata_o  = wdata_q;
  assign fifo_rready_o = pop_q;
  assign port_rsp_o    = '{ack: ack_q, err: err_q, rd_data: rdata_q};

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
// Synchronous circular-buffer FIFO with a registered entry count
// Head entry is visible on rdata_o whenever rvalid_o is high
`include "axi_csr_settings.svh"
`default_nettype none

module sync_fifo #(
  parameter type         T     = csr_pkg::fifo_word_t,
  parameter int unsigned Depth = `AXI_CSR_FIFO_DEPTH
) (
  input  wire logic                       aclk,
  input  wire logic                       areset_n,
  input  wire logic                       wvalid_i,
  output logic                            wready_o,
  input  wire T                           wdata_i,
  output logic                            rvalid_o,
  input  wire logic                       rready_i,
  output T                                rdata_o,
  output logic [$clog2(Depth+1)-1:0]      depth_o,
  output logic                            full_o
);
  localparam int unsigned PtrW   = $clog2(Depth);
  localparam int unsigned CountW = $clog2(Depth+1);

  T                  mem [Depth];
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CountW-1:0] count_q;
  logic              do_wr, do_rd;

  assign do_wr = wvalid_i & wready_o;
  assign do_rd = rvalid_o & rready_i;

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_rd) rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_wr && !do_rd) count_q <= count_q + 1'b1;
      else if (do_rd && !do_wr) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (do_wr) mem[wr_ptr_q] <= wdata_i;
  end

  assign full_o   = (count_q == CountW'(Depth));
  assign wready_o = ~full_o;
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem[rd_ptr_q];
  assign depth_o  = count_q;

endmodule

`default_nettype wire

/* i3c_axi_csr.f */
+incdir+design
design/axi_bus_pkg.sv
design/csr_pkg.sv
design/sync_fifo.sv
design/fifo_port_bridge.sv
design/csr_regs.sv
design/axi_csr_adapter.sv
design/axi_csr_top.sv
verif/axi_csr_checker.sv
verif/tb_axi_csr.sv

/* verif/axi_csr_checker.sv */
// Passive checker for the AXI CSR harness
// Predicts every R and B beat from a register-map model and compares it at the transfer
`include "axi_csr_settings.svh"
`default_nettype none

module axi_csr_checker (
  input  wire logic                        aclk,
  input  wire logic                        areset_n,
  input  wire axi_bus_pkg::axi_ar_t        ar_i,
  input  wire logic                        ar_valid_i,
  input  wire logic                        ar_ready_i,
  input  wire axi_bus_pkg::axi_aw_t        aw_i,
  input  wire logic                        aw_valid_i,
  input  wire logic                        aw_ready_i,
  input  wire axi_bus_pkg::axi_w_t         w_i,
  input  wire logic                        w_valid_i,
  input  wire logic                        w_ready_i,
  input  wire axi_bus_pkg::axi_r_t         r_i,
  input  wire logic                        r_valid_i,
  input  wire logic                        r_ready_i,
  input  wire axi_bus_pkg::axi_b_t         b_i,
  input  wire logic                        b_valid_i,
  input  wire logic                        b_ready_i,
  input  wire logic [`AXI_CSR_DEPTH_W-1:0] fifo_depth_i,
  input  wire logic                        fifo_full_i,
  output int unsigned                      err_cnt_o,
  output int unsigned                      chk_cnt_o
);
  import axi_bus_pkg::*;
  import csr_pkg::*;

  logic [31:0] scratch_m = '0;
  logic [31:0] fifo_m[$];  // Model of the stress FIFO, head at index 0
  axi_ar_t     ar_q[$];
  axi_aw_t     aw_q[$];
  axi_w_t      w_q[$];
  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  // Applies one access to the model and returns the expected response
  function automatic axi_resp_e predict(input logic is_wr, input logic [11:0] addr,
                                        input logic [31:0] wdata, input logic [3:0] strb,
                                        output logic [31:0] rdata);
    axi_resp_e resp;
    int        sz;
    resp  = OKAY;
    rdata = '0;
    sz    = fifo_m.size();
    case ({addr[11:2], 2'b00})
      ID_OFS: if (!is_wr) rdata = `AXI_CSR_ID_VALUE;
      SCRATCH_OFS: begin
        for (int i = 0; i < 4; i++) begin
          if (is_wr && strb[i]) scratch_m[8*i +: 8] = wdata[8*i +: 8];
        end
        if (!is_wr) rdata = scratch_m;
      end
      TX_DATA_OFS: begin
        if (is_wr && sz == `AXI_CSR_FIFO_DEPTH) resp = SLVERR;  // Overflow
        else if (is_wr) fifo_m.push_back(wdata);
      end
      FIFO_DATA_OFS: begin
        if (is_wr || sz == 0) resp = SLVERR;
        else rdata = fifo_m.pop_front();
      end
      STATUS_OFS: begin
        if (!is_wr) rdata = 32'(sz);
        if (!is_wr) rdata[8] = (sz == `AXI_CSR_FIFO_DEPTH);
      end
      default: resp = SLVERR;
    endcase
    return resp;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR time %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  always @(posedge aclk) begin : monitor
    axi_ar_t     ar;
    axi_aw_t     aw;
    axi_w_t      w;
    axi_resp_e   exp_resp;
    logic [31:0] exp_data;
    if (areset_n) begin
      if (ar_valid_i && ar_ready_i) ar_q.push_back(ar_i);
      if (aw_valid_i && aw_ready_i) aw_q.push_back(aw_i);
      if (w_valid_i && w_ready_i) w_q.push_back(w_i);
      if (r_valid_i && r_ready_i && ar_q.size() == 0) begin
        err_cnt++;
        $display("Read response at time %0t without an accepted read address", $time);
      end else if (r_valid_i && r_ready_i) begin
        ar       = ar_q.pop_front();
        exp_resp = predict(1'b0, ar.addr, '0, '0, exp_data);
        compare("r_o.data", exp_data, r_i.data);
        compare("r_o.resp", exp_resp, r_i.resp);
        compare("r_o.id", ar.id, r_i.id);
        compare("r_o.user", ar.user, r_i.user);
        compare("r_o.last", 1'b1, r_i.last);
      end
      if (b_valid_i && b_ready_i && (aw_q.size() == 0 || w_q.size() == 0)) begin
        err_cnt++;
        $display("Write response at time %0t without an accepted address and data", $time);
      end else if (b_valid_i && b_ready_i) begin
        aw       = aw_q.pop_front();
        w        = w_q.pop_front();
        exp_resp = predict(1'b1, aw.addr, w.data, w.strb, exp_data);
        compare("b_o.resp", exp_resp, b_i.resp);
        compare("b_o.id", aw.id, b_i.id);
        compare("b_o.user", aw.user, b_i.user);
      end
      if ((r_valid_i && r_ready_i) || (b_valid_i && b_ready_i)) begin
        compare("fifo_depth_o", fifo_m.size(), fifo_depth_i);
        compare("fifo_full_o", fifo_m.size() == `AXI_CSR_FIFO_DEPTH, fifo_full_i);
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_axi_csr.sv */
// Testbench top for the AXI CSR harness
// Drives AXI accesses on the falling edge, the checker instance judges the responses
`include "axi_csr_settings.svh"
`default_nettype none

module tb_axi_csr;
  import axi_bus_pkg::*;
  import csr_pkg::*;

  localparam int unsigned TIMEOUT = 200;  // Cycles per handshake

  typedef enum {CH_AR, CH_AW, CH_W, CH_R, CH_B} chan_e;

  logic                        aclk, areset_n;
  axi_ar_t                     ar_i;
  axi_aw_t                     aw_i;
  axi_w_t                      w_i;
  axi_r_t                      r_o;
  axi_b_t                      b_o;
  logic                        ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  logic                        w_valid_i, w_ready_o, r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  logic [`AXI_CSR_DEPTH_W-1:0] fifo_depth_o;
  logic                        fifo_full_o;
  int unsigned                 err_cnt, chk_cnt;
  int unsigned                 timeouts = 0;

  axi_csr_top dut_i (
    .aclk, .areset_n, .ar_i, .ar_valid_i, .ar_ready_o, .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o, .r_o, .r_valid_o, .r_ready_i,
    .b_o, .b_valid_o, .b_ready_i, .fifo_depth_o, .fifo_full_o
  );

  axi_csr_checker chk_i (
    .aclk, .areset_n, .ar_i, .ar_valid_i, .ar_ready_i(ar_ready_o),
    .aw_i, .aw_valid_i, .aw_ready_i(aw_ready_o), .w_i, .w_valid_i, .w_ready_i(w_ready_o),
    .r_i(r_o), .r_valid_i(r_valid_o), .r_ready_i, .b_i(b_o), .b_valid_i(b_valid_o), .b_ready_i,
    .fifo_depth_i(fifo_depth_o), .fifo_full_i(fifo_full_o),
    .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic xfer(input chan_e ch);
    case (ch)
      CH_AR:   return ar_valid_i & ar_ready_o;
      CH_AW:   return aw_valid_i & aw_ready_o;
      CH_W:    return w_valid_i & w_ready_o;
      CH_R:    return r_valid_o & r_ready_i;
      default: return b_valid_o & b_ready_i;
    endcase
  endfunction

  // Returns on the falling edge after the transfer, R and B ready toggle at random
  task automatic wait_xfer(input chan_e ch, input string what);
    int   n;
    logic done;
    n = 0;
    do begin
      if (ch == CH_R) r_ready_i = ($urandom_range(3) != 0);
      if (ch == CH_B) b_ready_i = ($urandom_range(3) != 0);
      @(posedge aclk);
      done = xfer(ch);
      @(negedge aclk);
      n++;
    end while (!done && n < TIMEOUT);
    if (!done) begin
      timeouts++;
      $display("Timeout at time %0t waiting for %s", $time, what);
    end
  endtask

  task automatic axi_read(input logic [11:0] addr);
    ar_i       = '{addr: addr, id: 8'($urandom), user: $urandom};
    ar_valid_i = 1'b1;
    wait_xfer(CH_AR, "read address accept");
    ar_valid_i = 1'b0;
    wait_xfer(CH_R, "read response");
    r_ready_i = 1'b0;
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int unsigned aw_dly, w_dly;
    aw_dly = $urandom_range(3);  // Skew between AW and W
    w_dly  = $urandom_range(3);
    aw_i   = '{addr: addr, id: 8'($urandom), user: $urandom};
    w_i    = '{data: data, strb: strb, user: $urandom};
    fork
      begin
        repeat (aw_dly) @(negedge aclk);
        aw_valid_i = 1'b1;
        wait_xfer(CH_AW, "write address accept");
        aw_valid_i = 1'b0;
      end
      begin
        repeat (w_dly) @(negedge aclk);
        w_valid_i = 1'b1;
        wait_xfer(CH_W, "write data accept");
        w_valid_i = 1'b0;
      end
    join
    wait_xfer(CH_B, "write response");
    b_ready_i = 1'b0;
  endtask

  task automatic random_access();
    logic [11:0] addr;
    addr = 12'(4 * $urandom_range(5));  // Mapped offsets plus one unmapped
    if ($urandom_range(1) != 0) axi_write(addr, $urandom, 4'($urandom));
    else axi_read(addr);
  endtask

  initial begin
    void'($urandom(32'hcd09));
    areset_n   = 1'b0;
    ar_i       = '0;
    aw_i       = '0;
    w_i        = '0;
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    areset_n = 1'b1;
    @(negedge aclk);
    axi_read(ID_OFS);
    axi_write(SCRATCH_OFS, $urandom, 4'hf);
    repeat (6) begin
      axi_write(SCRATCH_OFS, $urandom, 4'($urandom));
      axi_read(SCRATCH_OFS);
    end
    axi_write(ID_OFS, $urandom, 4'hf);
    axi_write(STATUS_OFS, $urandom, 4'hf);
    axi_read(ID_OFS);
    axi_read(STATUS_OFS);
    axi_read(12'h014);
    axi_read(12'h7fc);
    axi_write(FIFO_DATA_OFS, $urandom, 4'hf);
    axi_write(12'h100, $urandom, 4'hf);
    repeat (10) axi_write(TX_DATA_OFS, $urandom, 4'hf);
    axi_read(STATUS_OFS);
    repeat (12) axi_read(FIFO_DATA_OFS);  // Last two hit an empty FIFO
    repeat (`AXI_CSR_FIFO_DEPTH + 1) axi_write(TX_DATA_OFS, $urandom, 4'hf);
    axi_read(STATUS_OFS);
    repeat (`AXI_CSR_FIFO_DEPTH) axi_read(FIFO_DATA_OFS);
    axi_read(STATUS_OFS);
    repeat (80) random_access();
    $display("Checks %0d, mismatches %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0 && chk_cnt > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
